// ==== hw/pma_consts.svh ====
// PMA checker constants
// Field codes keep the gaps of the wider region record; codes 2, 3, 5-7 are unused
// Attribute bits above PMA_AT_C are stored but not interpreted
// Vacant regions still match 0xFFFFFFF0 and up; region 7 must cover that range
`ifndef PMA_CONSTS_SVH
`define PMA_CONSTS_SVH

// ====================
// Table geometry
// ====================
`define PMA_NUM_REGIONS 8
`define PMA_GRAIN_LSB 4

// Field codes in the low three bits of the config address
`define PMA_FLD_START 3'd0
`define PMA_FLD_END 3'd1
`define PMA_FLD_ATTR 3'd4

// Attribute bit positions
`define PMA_AT_X 0
`define PMA_AT_W 1
`define PMA_AT_R 2
`define PMA_AT_C 3

// ====================
// Default map
// ====================
`define PMA_VACANT_ADDR 32'hFFFFFFFF
`define PMA_VACANT_ATTR 20'h00000

// Boot ROM, read and execute, cacheable
`define PMA_ROM_REGION 7
`define PMA_ROM_START 32'hFFFD0000
`define PMA_ROM_END 32'hFFFFFFFF
`define PMA_ROM_ATTR 20'h0000D

// Scratchpad RAM, full rights
`define PMA_SPAD_REGION 4
`define PMA_SPAD_START 32'hFFFC0000
`define PMA_SPAD_END 32'hFFFCFFFF
`define PMA_SPAD_ATTR 20'h0000F

// Main DRAM, full rights
`define PMA_DRAM_REGION 1
`define PMA_DRAM_START 32'h00000000
`define PMA_DRAM_END 32'h1FFFFFFF
`define PMA_DRAM_ATTR 20'h0000F

`endif

// ==== hw/pma_types_pkg.sv ====
// Data-width types shared by the PMA checker
// Region index width follows the region count in the constants header
`default_nettype none

`include "pma_consts.svh"

package pma_types_pkg;

	// Byte address on the processor side
	typedef logic [31:0] addr_t;

	// Configuration port data word
	typedef logic [31:0] word_t;

	// Stored attribute field, only the low four bits mean anything
	typedef logic [19:0] attr_t;

	// Region number, highest wins on overlap
	typedef logic [$clog2(`PMA_NUM_REGIONS)-1:0] region_idx_t;

	// Config address is {region, field code}
	typedef logic [5:0] cfg_adr_t;

endpackage

`default_nettype wire

// ==== hw/pma_access_pkg.sv ====
// Access kinds, fault codes and arbiter state
// Fault codes are 2 bits wide on the top-level ports
`default_nettype none

package pma_access_pkg;

	// What the requester wants to do with the address
	typedef enum logic [1:0] {
		acc_fetch = 2'd0,
		acc_load  = 2'd1,
		acc_store = 2'd2
	} acc_kind_t;

	// Checker verdict
	typedef enum logic [1:0] {
		flt_none      = 2'd0,
		flt_no_region = 2'd1,
		flt_denied    = 2'd2
	} fault_t;

	// Which checker the arbiter served most recently
	typedef enum logic {
		arb_last_fetch = 1'b0,
		arb_last_data  = 1'b1
	} arb_state_t;

endpackage

`default_nettype wire

// ==== hw/pma_lookup_if.sv ====
// One lookup channel into the region table
// lreq is a level held until lgnt; results are valid while lgnt is high
`timescale 1ns/1ns
`default_nettype none

interface pma_lookup_if;
	import pma_types_pkg::*;
	import pma_access_pkg::*;

	// Request side
	logic lreq;
	addr_t laddr;
	acc_kind_t lkind;

	// Grant and table result
	logic lgnt;
	logic lhit;
	region_idx_t lregion;
	attr_t lattr;

	modport requester (output lreq, laddr, lkind, input lgnt, lhit, lregion, lattr);
	modport arbiter_side (input lreq, laddr, lkind, output lgnt, lhit, lregion, lattr);
	// Table acknowledges every request in the same cycle
	modport table_side (input lreq, laddr, output lgnt, lhit, lregion, lattr);

endinterface

`default_nettype wire

// ==== hw/pma_region_table.sv ====
// Eight-entry PMA region table with config port and combinational lookup
// Only start, end and attribute fields exist; other codes read zero, ignore writes
// cfg_rdata lags cfg_adr by one cycle
// Overlapping regions resolve to the highest index
`timescale 1ns/1ns
`default_nettype none

`include "pma_consts.svh"

module pma_region_table (
	input logic clk,
	input logic rst,
	input logic cfg_wr,
	input pma_types_pkg::cfg_adr_t cfg_adr,
	input pma_types_pkg::word_t cfg_wdata,
	output pma_types_pkg::word_t cfg_rdata,
	pma_lookup_if.table_side lk
);
	import pma_types_pkg::*;

	// Region storage
	addr_t start_q [`PMA_NUM_REGIONS];
	addr_t end_q [`PMA_NUM_REGIONS];
	attr_t attr_q [`PMA_NUM_REGIONS];

	// Config address split
	region_idx_t cfg_region;
	logic [2:0] cfg_field;

	assign cfg_region = cfg_adr[5:3];
	assign cfg_field = cfg_adr[2:0];

	// ====================
	// Config write
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			// Everything vacant first
			for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
				start_q[i] <= `PMA_VACANT_ADDR;
				end_q[i] <= `PMA_VACANT_ADDR;
				attr_q[i] <= `PMA_VACANT_ATTR;
			end
			// Then the populated regions of the boot map
			start_q[`PMA_ROM_REGION] <= `PMA_ROM_START;
			end_q[`PMA_ROM_REGION] <= `PMA_ROM_END;
			attr_q[`PMA_ROM_REGION] <= `PMA_ROM_ATTR;
			start_q[`PMA_SPAD_REGION] <= `PMA_SPAD_START;
			end_q[`PMA_SPAD_REGION] <= `PMA_SPAD_END;
			attr_q[`PMA_SPAD_REGION] <= `PMA_SPAD_ATTR;
			start_q[`PMA_DRAM_REGION] <= `PMA_DRAM_START;
			end_q[`PMA_DRAM_REGION] <= `PMA_DRAM_END;
			attr_q[`PMA_DRAM_REGION] <= `PMA_DRAM_ATTR;
		end else if (cfg_wr) begin
			case (cfg_field)
				`PMA_FLD_START: start_q[cfg_region] <= cfg_wdata;
				`PMA_FLD_END: end_q[cfg_region] <= cfg_wdata;
				// Upper data bits dropped
				`PMA_FLD_ATTR: attr_q[cfg_region] <= attr_t'(cfg_wdata);
				default: ;
			endcase
		end
	end

	// ====================
	// Config read
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_rdata <= '0;
		end else begin
			case (cfg_field)
				`PMA_FLD_START: cfg_rdata <= start_q[cfg_region];
				`PMA_FLD_END: cfg_rdata <= end_q[cfg_region];
				`PMA_FLD_ATTR: cfg_rdata <= word_t'(attr_q[cfg_region]);
				// Unused slots always read zero
				default: cfg_rdata <= '0;
			endcase
		end
	end

	// ====================
	// Address lookup
	// ====================
	// Never stalls a lookup
	assign lk.lgnt = lk.lreq;

	// Later matches overwrite earlier ones, so the top index wins
	always_comb begin
		lk.lhit = 1'b0;
		lk.lregion = '0;
		lk.lattr = '0;
		for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
			// Inclusive bounds at 16-byte grain
			if (lk.laddr[31:`PMA_GRAIN_LSB] >= start_q[i][31:`PMA_GRAIN_LSB] &&
				lk.laddr[31:`PMA_GRAIN_LSB] <= end_q[i][31:`PMA_GRAIN_LSB]) begin
				lk.lhit = 1'b1;
				lk.lregion = region_idx_t'(i);
				lk.lattr = attr_q[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/pma_lookup_arbiter.sv ====
// Round-robin arbiter for the table's single lookup port
// Fetch wins a tie after reset, then turns alternate
// Table result is broadcast; only the granted checker samples it
`timescale 1ns/1ns
`default_nettype none

module pma_lookup_arbiter (
	input logic clk,
	input logic rst,
	pma_lookup_if.arbiter_side fetch_lk,
	pma_lookup_if.arbiter_side data_lk,
	pma_lookup_if.requester tbl_lk
);
	import pma_access_pkg::*;

	// Last side served
	arb_state_t last_q;

	logic fetch_sel;
	logic data_sel;

	// ====================
	// Selection
	// ====================
	always_comb begin
		// Fetch goes if alone or if data went last
		fetch_sel = fetch_lk.lreq && (!data_lk.lreq || last_q == arb_last_data);
		data_sel = data_lk.lreq && !fetch_sel;
	end

	// Forward the chosen request downstream
	assign tbl_lk.lreq = fetch_sel | data_sel;
	assign tbl_lk.laddr = fetch_sel ? fetch_lk.laddr : data_lk.laddr;
	assign tbl_lk.lkind = fetch_sel ? fetch_lk.lkind : data_lk.lkind;

	// Grant only once the table takes it
	assign fetch_lk.lgnt = fetch_sel && tbl_lk.lgnt;
	assign data_lk.lgnt = data_sel && tbl_lk.lgnt;

	// Result fan-out
	assign fetch_lk.lhit = tbl_lk.lhit;
	assign fetch_lk.lregion = tbl_lk.lregion;
	assign fetch_lk.lattr = tbl_lk.lattr;
	assign data_lk.lhit = tbl_lk.lhit;
	assign data_lk.lregion = tbl_lk.lregion;
	assign data_lk.lattr = tbl_lk.lattr;

	// ====================
	// Turn tracking
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			// Pretend data went last so fetch leads
			last_q <= arb_last_data;
		end else if (fetch_lk.lgnt) begin
			last_q <= arb_last_fetch;
		end else if (data_lk.lgnt) begin
			last_q <= arb_last_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/pma_access_checker.sv ====
// Single-request permission checker
// req is ignored while busy; done pulses 2 or 3 cycles after the strobe
// fault, region and cacheable hold from done until the next done
// In fetch mode the store input has no effect
`timescale 1ns/1ns
`default_nettype none

`include "pma_consts.svh"

module pma_access_checker #(
	parameter bit FETCH_PORT = 1'b0
) (
	input logic clk,
	input logic rst,
	input logic req,
	input pma_types_pkg::addr_t addr,
	input logic store,
	output logic busy,
	output logic done,
	output pma_access_pkg::fault_t fault,
	output pma_types_pkg::region_idx_t region,
	output logic cacheable,
	pma_lookup_if.requester lk
);
	import pma_types_pkg::*;
	import pma_access_pkg::*;

	// Captured request
	addr_t addr_q;
	acc_kind_t kind_q;

	// Needed attribute bit is present
	logic perm_ok;

	// Hold the lookup while waiting for a turn
	assign lk.lreq = busy;
	assign lk.laddr = addr_q;
	assign lk.lkind = kind_q;

	always_comb begin
		case (kind_q)
			acc_fetch: perm_ok = lk.lattr[`PMA_AT_X];
			acc_load: perm_ok = lk.lattr[`PMA_AT_R];
			acc_store: perm_ok = lk.lattr[`PMA_AT_W];
			default: perm_ok = 1'b0;
		endcase
	end

	// ====================
	// Control
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy && req) begin
				busy <= 1'b1;
			end else if (busy && lk.lgnt) begin
				// Result lands now, done shows next cycle
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// ====================
	// Request and result
	// ====================
	always_ff @(posedge clk) begin
		if (!busy && req) begin
			addr_q <= addr;
			if (FETCH_PORT)
				kind_q <= acc_fetch;
			else if (store)
				kind_q <= acc_store;
			else
				kind_q <= acc_load;
		end
		if (busy && lk.lgnt) begin
			// Missing region beats missing permission
			if (!lk.lhit)
				fault <= flt_no_region;
			else if (!perm_ok)
				fault <= flt_denied;
			else
				fault <= flt_none;
			region <= lk.lregion;
			cacheable <= lk.lhit && lk.lattr[`PMA_AT_C];
		end
	end

endmodule

`default_nettype wire

// ==== hw/pma_check_top.sv ====
// PMA checker top level
// Fetch and data checkers share one table lookup per cycle
// Config writes are seen by lookups from the next cycle on
`timescale 1ns/1ns
`default_nettype none

module pma_check_top (
	input logic clk,
	input logic rst,
	// Config port
	input logic cfg_wr,
	input pma_types_pkg::cfg_adr_t cfg_adr,
	input pma_types_pkg::word_t cfg_wdata,
	output pma_types_pkg::word_t cfg_rdata,
	// Instruction fetch
	input logic if_req,
	input pma_types_pkg::addr_t if_addr,
	output logic if_busy,
	output logic if_done,
	output pma_access_pkg::fault_t if_fault,
	output pma_types_pkg::region_idx_t if_region,
	output logic if_cacheable,
	// Data access
	input logic dp_req,
	input pma_types_pkg::addr_t dp_addr,
	input logic dp_store,
	output logic dp_busy,
	output logic dp_done,
	output pma_access_pkg::fault_t dp_fault,
	output pma_types_pkg::region_idx_t dp_region,
	output logic dp_cacheable
);

	// Checker to arbiter, arbiter to table
	pma_lookup_if fetch_lk ();
	pma_lookup_if data_lk ();
	pma_lookup_if tbl_lk ();

	pma_region_table table_i (
		.clk(clk),
		.rst(rst),
		.cfg_wr(cfg_wr),
		.cfg_adr(cfg_adr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.lk(tbl_lk.table_side)
	);

	pma_lookup_arbiter arbiter_i (
		.clk(clk),
		.rst(rst),
		.fetch_lk(fetch_lk.arbiter_side),
		.data_lk(data_lk.arbiter_side),
		.tbl_lk(tbl_lk.requester)
	);

	// Fetch side always checks execute
	pma_access_checker #(.FETCH_PORT(1'b1)) fetch_chk_i (
		.clk(clk),
		.rst(rst),
		.req(if_req),
		.addr(if_addr),
		.store(1'b0),
		.busy(if_busy),
		.done(if_done),
		.fault(if_fault),
		.region(if_region),
		.cacheable(if_cacheable),
		.lk(fetch_lk.requester)
	);

	// Data side checks read or write by dp_store
	pma_access_checker #(.FETCH_PORT(1'b0)) data_chk_i (
		.clk(clk),
		.rst(rst),
		.req(dp_req),
		.addr(dp_addr),
		.store(dp_store),
		.busy(dp_busy),
		.done(dp_done),
		.fault(dp_fault),
		.region(dp_region),
		.cacheable(dp_cacheable),
		.lk(data_lk.requester)
	);

endmodule

`default_nettype wire

// ==== sim/pma_check_monitor.sv ====
// Result checker for the PMA checker testbench
// Samples DUT outputs on the rising edge against expected values from the testbench
// Latency runs from the accepting edge to the edge that sees done
`timescale 1ns/1ns
`default_nettype none

module pma_check_monitor (
	input logic clk,
	input logic rst,
	// Fetch side
	input logic if_req,
	input logic if_busy,
	input logic if_done,
	input pma_access_pkg::fault_t if_fault,
	input pma_types_pkg::region_idx_t if_region,
	input logic if_cacheable,
	// Data side
	input logic dp_req,
	input logic dp_busy,
	input logic dp_done,
	input pma_access_pkg::fault_t dp_fault,
	input pma_types_pkg::region_idx_t dp_region,
	input logic dp_cacheable,
	input pma_types_pkg::word_t cfg_rdata,
	// Expected values
	input int tnum,
	input logic exp_if_on,
	input pma_access_pkg::fault_t exp_if_fault,
	input pma_types_pkg::region_idx_t exp_if_region,
	input logic exp_if_cacheable,
	input logic exp_dp_on,
	input pma_access_pkg::fault_t exp_dp_fault,
	input pma_types_pkg::region_idx_t exp_dp_region,
	input logic exp_dp_cacheable,
	input pma_types_pkg::word_t exp_rdata,
	// Check strobes
	input logic rd_check,
	input logic idle_check,
	input logic test_end,
	input logic timed_out,
	output int pass_cnt,
	output int fail_cnt
);

	int test_errs;
	int if_lat;
	int dp_lat;
	int if_want_lat;
	int dp_want_lat;
	logic if_pend;
	logic dp_pend;
	// Which side the arbiter served most recently
	logic fetch_last;

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: test %0d %s got 0x%0h, expected 0x%0h",
				$time, tnum, name, got, exp);
			test_errs++;
		end
	endtask

	// Strobe-to-done latency in cycles
	task automatic check_latency(input string side, input int lat, input int want);
		if (lat != want) begin
			$display("Mismatch at time %0t: test %0d %s latency %0d cycles, expected %0d",
				$time, tnum, side, lat, want);
			test_errs++;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			if_pend = 1'b0;
			dp_pend = 1'b0;
			if_lat = 0;
			dp_lat = 0;
			if_want_lat = 2;
			dp_want_lat = 2;
			// Fetch leads after reset
			fetch_last = 1'b0;
			test_errs = 0;
			pass_cnt = 0;
			fail_cnt = 0;
		end else begin
			if (if_pend)
				if_lat++;
			if (dp_pend)
				dp_lat++;

			// ====================
			// Result checks
			// ====================
			if (if_done) begin
				if (if_pend && exp_if_on) begin
					compare_field("if_fault", 32'(if_fault), 32'(exp_if_fault));
					compare_field("if_region", 32'(if_region), 32'(exp_if_region));
					compare_field("if_cacheable", 32'(if_cacheable), 32'(exp_if_cacheable));
					check_latency("fetch", if_lat, if_want_lat);
				end else begin
					$display("test %0d: fetch done pulsed with no fetch pending", tnum);
					test_errs++;
				end
				if_pend = 1'b0;
				fetch_last = 1'b1;
			end
			if (dp_done) begin
				if (dp_pend && exp_dp_on) begin
					compare_field("dp_fault", 32'(dp_fault), 32'(exp_dp_fault));
					compare_field("dp_region", 32'(dp_region), 32'(exp_dp_region));
					compare_field("dp_cacheable", 32'(dp_cacheable), 32'(exp_dp_cacheable));
					check_latency("data", dp_lat, dp_want_lat);
				end else begin
					$display("test %0d: data done pulsed with no data access pending", tnum);
					test_errs++;
				end
				dp_pend = 1'b0;
				fetch_last = 1'b0;
			end

			// Accepted strobe starts the count
			// A lone request is granted at once
			if (if_req && !if_busy) begin
				if_pend = 1'b1;
				if_lat = 0;
				if_want_lat = 2;
			end
			if (dp_req && !dp_busy) begin
				dp_pend = 1'b1;
				dp_lat = 0;
				dp_want_lat = 2;
			end
			// Same-cycle requests let the side not served last go first
			if (if_req && !if_busy && dp_req && !dp_busy) begin
				if (fetch_last)
					if_want_lat = 3;
				else
					dp_want_lat = 3;
			end

			if (rd_check)
				compare_field("cfg_rdata", cfg_rdata, exp_rdata);
			// Quiet outputs right after reset
			if (idle_check) begin
				compare_field("if_busy", 32'(if_busy), 32'd0);
				compare_field("dp_busy", 32'(dp_busy), 32'd0);
				compare_field("if_done", 32'(if_done), 32'd0);
				compare_field("dp_done", 32'(dp_done), 32'd0);
			end

			// ====================
			// Per-test verdict
			// ====================
			if (test_end) begin
				if (timed_out)
					test_errs++;
				if (test_errs == 0) begin
					$display("test %0d passed", tnum);
					pass_cnt++;
				end else begin
					$display("test %0d failed with %0d errors", tnum, test_errs);
					fail_cnt++;
				end
				test_errs = 0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/pma_check_tb.sv ====
// Testbench for the PMA checker
// Reads sim/pma_check_testdata.txt relative to the project root
// Inputs change on the falling edge; the monitor samples on the rising edge
// Each wait for done gives up after 10 cycles
`timescale 1ns/1ns
`default_nettype none

module pma_check_tb;
	import pma_types_pkg::*;
	import pma_access_pkg::*;

	// ====================
	// DUT signals
	// ====================
	logic clk = 1'b0;
	logic rst;
	logic cfg_wr;
	cfg_adr_t cfg_adr;
	word_t cfg_wdata;
	word_t cfg_rdata;
	logic if_req;
	addr_t if_addr;
	logic if_busy;
	logic if_done;
	fault_t if_fault;
	region_idx_t if_region;
	logic if_cacheable;
	logic dp_req;
	addr_t dp_addr;
	logic dp_store;
	logic dp_busy;
	logic dp_done;
	fault_t dp_fault;
	region_idx_t dp_region;
	logic dp_cacheable;

	// Expected values and check strobes for the monitor
	logic exp_if_on;
	fault_t exp_if_fault;
	region_idx_t exp_if_region;
	logic exp_if_cacheable;
	logic exp_dp_on;
	fault_t exp_dp_fault;
	region_idx_t exp_dp_region;
	logic exp_dp_cacheable;
	word_t exp_rdata;
	logic rd_check;
	logic idle_check;
	logic test_end;
	logic timed_out;
	int pass_cnt;
	int fail_cnt;

	// Test data fields
	int fd;
	int code;
	int tnum;
	int gap;
	int seed = 32'h35bc;
	logic [7:0] op;
	logic [31:0] a1;
	logic [31:0] d1;
	logic [31:0] a2;
	logic [31:0] d2;
	int f1;
	int r1;
	int c1;
	int f2;
	int r2;
	int c2;
	logic [8*256-1:0] skip_line;
	logic file_err;

	// 40 ns period
	always #20 clk = ~clk;

	pma_check_top dut_i (
		.clk(clk),
		.rst(rst),
		.cfg_wr(cfg_wr),
		.cfg_adr(cfg_adr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.if_req(if_req),
		.if_addr(if_addr),
		.if_busy(if_busy),
		.if_done(if_done),
		.if_fault(if_fault),
		.if_region(if_region),
		.if_cacheable(if_cacheable),
		.dp_req(dp_req),
		.dp_addr(dp_addr),
		.dp_store(dp_store),
		.dp_busy(dp_busy),
		.dp_done(dp_done),
		.dp_fault(dp_fault),
		.dp_region(dp_region),
		.dp_cacheable(dp_cacheable)
	);

	pma_check_monitor mon_i (.*);

	// ====================
	// Stimulus tasks
	// ====================
	// Fetch strobe plus what it should return
	task automatic set_fetch(input addr_t addr, input int f, input int r, input int c);
		if_req = 1'b1;
		if_addr = addr;
		exp_if_on = 1'b1;
		exp_if_fault = fault_t'(f[1:0]);
		exp_if_region = r[2:0];
		exp_if_cacheable = c[0];
	endtask

	task automatic set_data(input addr_t addr, input logic st, input int f, input int r,
		input int c);
		dp_req = 1'b1;
		dp_addr = addr;
		dp_store = st;
		exp_dp_on = 1'b1;
		exp_dp_fault = fault_t'(f[1:0]);
		exp_dp_region = r[2:0];
		exp_dp_cacheable = c[0];
	endtask

	// Drops the strobes after one cycle, then polls done
	task automatic wait_done(input logic want_if, input logic want_dp);
		int cycles;
		logic got_if;
		logic got_dp;
		cycles = 0;
		got_if = !want_if;
		got_dp = !want_dp;
		while (!(got_if && got_dp) && cycles < 10) begin
			@(negedge clk);
			if_req = 1'b0;
			dp_req = 1'b0;
			cycles++;
			if (if_done)
				got_if = 1'b1;
			if (dp_done)
				got_dp = 1'b1;
		end
		if (!(got_if && got_dp)) begin
			$display("timeout waiting for done on test %0d", tnum);
			timed_out = 1'b1;
		end
	endtask

	// Monitor closes the test on the next rising edge
	task automatic finish_test();
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
		timed_out = 1'b0;
		rd_check = 1'b0;
		idle_check = 1'b0;
		exp_if_on = 1'b0;
		exp_dp_on = 1'b0;
	endtask

	task automatic run_op();
		case (op)
			"I": begin
				idle_check = 1'b1;
				finish_test();
			end
			"W": begin
				cfg_wr = 1'b1;
				cfg_adr = cfg_adr_t'(a1);
				cfg_wdata = d1;
				@(negedge clk);
				cfg_wr = 1'b0;
				finish_test();
			end
			"R": begin
				// Read data is registered, check one cycle later
				cfg_adr = cfg_adr_t'(a1);
				exp_rdata = d1;
				@(negedge clk);
				rd_check = 1'b1;
				finish_test();
			end
			"F": begin
				set_fetch(a1, f1, r1, c1);
				wait_done(1'b1, 1'b0);
				finish_test();
			end
			"L", "S": begin
				set_data(a1, op == "S", f1, r1, c1);
				wait_done(1'b0, 1'b1);
				finish_test();
			end
			"P": begin
				// Both strobes in the same cycle
				set_fetch(a1, f1, r1, c1);
				set_data(a2, d2[0], f2, r2, c2);
				wait_done(1'b1, 1'b1);
				finish_test();
			end
			default: begin
				$display("unknown operation in test data after test %0d", tnum);
				file_err = 1'b1;
			end
		endcase
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		rst = 1'b1;
		cfg_wr = 1'b0;
		cfg_adr = '0;
		cfg_wdata = '0;
		if_req = 1'b0;
		if_addr = '0;
		dp_req = 1'b0;
		dp_addr = '0;
		dp_store = 1'b0;
		exp_if_on = 1'b0;
		exp_if_fault = flt_none;
		exp_if_region = '0;
		exp_if_cacheable = 1'b0;
		exp_dp_on = 1'b0;
		exp_dp_fault = flt_none;
		exp_dp_region = '0;
		exp_dp_cacheable = 1'b0;
		exp_rdata = '0;
		rd_check = 1'b0;
		idle_check = 1'b0;
		test_end = 1'b0;
		timed_out = 1'b0;
		file_err = 1'b0;
		tnum = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		fd = $fopen("sim/pma_check_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/pma_check_testdata.txt");
			file_err = 1'b1;
		end else begin
			while ($fscanf(fd, "%s", op) == 1) begin
				if (op == "#") begin
					code = $fgets(skip_line, fd);
				end else begin
					code = $fscanf(fd, "%d %h %h %d %d %d %h %h %d %d %d",
						tnum, a1, d1, f1, r1, c1, a2, d2, f2, r2, c2);
					if (code != 11) begin
						$display("malformed test data line after test %0d", tnum);
						file_err = 1'b1;
					end else begin
						run_op();
						// Idle gap of 0 to 2 cycles
						gap = $unsigned($random(seed)) % 3;
						repeat (gap) @(negedge clk);
					end
				end
			end
			$fclose(fd);
		end
		$display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt > 0 && !file_err)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pma_check_top.f ====
+incdir+hw
hw/pma_types_pkg.sv
hw/pma_access_pkg.sv
hw/pma_lookup_if.sv
hw/pma_region_table.sv
hw/pma_lookup_arbiter.sv
hw/pma_access_checker.sv
hw/pma_check_top.sv
sim/pma_check_monitor.sv
sim/pma_check_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PMA checker testbench with Verilator.
# Paths resolve against the project root, where this script lives.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 -f pma_check_top.f \
	--top-module pma_check_tb -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vpma_check_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' <<< "$sim_out"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

// ==== sim/pma_check_testdata.txt ====
# op test a1 d1 f1 r1 c1 a2 d2 f2 r2 c2 (addresses and data in hex, others decimal)
# I idle, W/R config (a1 cfg address, d1 data), F/L/S a1 address, P fetch a1 plus data a2 (d2 store)
# Fault codes: 0 none, 1 no region, 2 denied
I 1 0 0 0 0 0 0 0 0 0 0
R 2 38 FFFD0000 0 0 0 0 0 0 0 0
L 3 00001000 0 0 1 1 0 0 0 0 0
S 4 FFFD0100 0 2 7 1 0 0 0 0 0
F 5 80000000 0 1 0 0 0 0 0 0 0
W 6 34 00000006 0 0 0 0 0 0 0 0
R 7 34 00000006 0 0 0 0 0 0 0 0
W 8 32 DEADBEEF 0 0 0 0 0 0 0 0
R 9 32 00000000 0 0 0 0 0 0 0 0
W 10 30 10000000 0 0 0 0 0 0 0 0
W 11 31 100FFFFF 0 0 0 0 0 0 0 0
W 12 34 00000004 0 0 0 0 0 0 0 0
R 13 31 100FFFFF 0 0 0 0 0 0 0 0
S 14 10000040 0 2 6 0 0 0 0 0 0
L 15 100FFFF0 0 0 6 0 0 0 0 0 0
L 16 10100000 0 0 1 1 0 0 0 0 0
P 17 FFFC0200 0 0 4 1 00002000 0 0 1 1
W 18 34 00000006 0 0 0 0 0 0 0 0
P 19 10000100 0 2 6 0 10000200 1 0 6 0
P 20 FFFF0000 0 0 7 1 80000000 0 1 0 0
S 21 FFFCFFF0 0 0 4 1 0 0 0 0 0
L 22 20000000 0 1 0 0 0 0 0 0 0
R 23 09 1FFFFFFF 0 0 0 0 0 0 0 0
R 24 00 FFFFFFFF 0 0 0 0 0 0 0 0
F 25 1FFFFFF0 0 0 1 1 0 0 0 0 0
